/* apbDebug.sv */
`timescale 1ns/1ps
`default_nettype none

module apbDebug import cpuPkg::*; (
	input wire clk,
	input wire reset,
	input wire psel,
	input wire penable,
	input wire pwrite,
	input wire logic [APB_ADDR_W-1:0] paddr,
	input wire dataT pwdata,
	output dataT prdata,
	output logic pready,
	output logic pslverr,
	input wire haltSeen,
	output logic run,
	output logic start,
	output logic imemWe,
	output memAddrT imemAddr,
	output instrT imemData,
	output regAddrT dbgRegAddr,
	output memAddrT dbgMemAddr,
	input wire dataT dbgRegData,
	input wire dataT dbgMemData
);

	runStateT state;
	logic setup, access;
	logic ctrlHit, regHit, imemHit, dmemHit;
	logic accessErr;
	dataT readData;

	assign setup = psel && !penable;
	assign access = psel && penable;

	// Address decode
	assign ctrlHit = (paddr == APB_CTRL);
	assign regHit = (paddr[APB_ADDR_W-1:5] == APB_REG_BASE[APB_ADDR_W-1:5]);
	assign imemHit = (paddr[APB_ADDR_W-1:10] == APB_IMEM_BASE[APB_ADDR_W-1:10]);
	assign dmemHit = (paddr[APB_ADDR_W-1:10] == APB_DMEM_BASE[APB_ADDR_W-1:10]);

	// Register and data windows are read-only, program window write-only
	always_comb begin
		if (ctrlHit) begin
			accessErr = 1'b0;
		end else if (regHit || dmemHit) begin
			accessErr = pwrite;
		end else if (imemHit) begin
			accessErr = !pwrite || (state == RUNNING);
		end else begin
			accessErr = 1'b1;
		end
	end

	// Debug read mux
	always_comb begin
		if (ctrlHit) begin
			readData = {14'b0, (state == HALTED), (state == RUNNING)};
		end else if (regHit) begin
			readData = dbgRegData;
		end else if (dmemHit) begin
			readData = dbgMemData;
		end else begin
			readData = '0;
		end
	end

	// Response captured in setup, presented through the access phase
	always_ff @(posedge clk) begin
		if (reset) begin
			prdata <= '0;
			pslverr <= 1'b0;
		end else if (setup) begin
			prdata <= pwrite ? '0 : readData;
			pslverr <= accessErr;
		end else if (access) begin
			prdata <= '0;
			pslverr <= 1'b0;
		end
	end

	// No wait states
	assign pready = 1'b1;

	assign dbgRegAddr = paddr[4:2];
	assign dbgMemAddr = paddr[9:2];

	// Program load commits on the edge ending an error-free access
	assign imemWe = access && pwrite && imemHit && !pslverr;
	assign imemAddr = paddr[9:2];
	assign imemData = pwdata;

	assign start = access && pwrite && ctrlHit && pwdata[0];

	// Run control, start wins over a halt in the same cycle
	always_ff @(posedge clk) begin
		if (reset) begin
			state <= IDLE;
		end else if (start) begin
			state <= RUNNING;
		end else if ((state == RUNNING) && haltSeen) begin
			state <= HALTED;
		end
	end

	// Fetch stops already in the cycle HALT executes
	assign run = (state == RUNNING) && !haltSeen;

endmodule

`default_nettype wire

/* cpuPkg.sv */
`default_nettype none

package cpuPkg;

	// Word and field widths
	typedef logic [15:0] dataT;
	typedef logic [15:0] instrT;
	typedef logic [2:0] regAddrT;
	// Word index into either memory, also the PC
	typedef logic [7:0] memAddrT;
	typedef logic [2:0] aluOpT;
	// N, Z, C, V from bit 3 down to bit 0
	typedef logic [3:0] flagsT;
	typedef logic [1:0] resSelT;

	// Debug run control
	typedef enum logic [1:0] {
		IDLE,
		RUNNING,
		HALTED
	} runStateT;

	localparam int NUM_REGS = 8;
	localparam int IMEM_DEPTH = 256;
	localparam int DMEM_DEPTH = 256;

	// Opcodes in instr[15:12]
	localparam logic [3:0] OP_ADD = 4'd0;
	localparam logic [3:0] OP_SUB = 4'd1;
	localparam logic [3:0] OP_AND = 4'd2;
	localparam logic [3:0] OP_ORR = 4'd3;
	localparam logic [3:0] OP_XOR = 4'd4;
	localparam logic [3:0] OP_ADDI = 4'd5;
	localparam logic [3:0] OP_MOVI = 4'd6;
	localparam logic [3:0] OP_LSL = 4'd7;
	localparam logic [3:0] OP_LSR = 4'd8;
	localparam logic [3:0] OP_LDR = 4'd9;
	localparam logic [3:0] OP_STR = 4'd10;
	localparam logic [3:0] OP_BCOND = 4'd11;
	localparam logic [3:0] OP_B = 4'd12;
	localparam logic [3:0] OP_HALT = 4'd13;
	localparam logic [3:0] OP_NOP = 4'd14;
	// Unassigned, executes as NOP
	localparam logic [3:0] OP_RSVD = 4'd15;

	// Branch conditions, anything above COND_LT is always
	localparam logic [3:0] COND_EQ = 4'd0;
	localparam logic [3:0] COND_NE = 4'd1;
	localparam logic [3:0] COND_CS = 4'd2;
	localparam logic [3:0] COND_CC = 4'd3;
	localparam logic [3:0] COND_MI = 4'd4;
	localparam logic [3:0] COND_PL = 4'd5;
	localparam logic [3:0] COND_VS = 4'd6;
	localparam logic [3:0] COND_VC = 4'd7;
	localparam logic [3:0] COND_GE = 4'd8;
	localparam logic [3:0] COND_LT = 4'd9;

	// Flag bit positions
	localparam int FLAG_N = 3;
	localparam int FLAG_Z = 2;
	localparam int FLAG_C = 1;
	localparam int FLAG_V = 0;

	// ALU operations, ADDI adds the immediate instead of operand B
	localparam aluOpT ALU_ADD = 3'd0;
	localparam aluOpT ALU_SUB = 3'd1;
	localparam aluOpT ALU_AND = 3'd2;
	localparam aluOpT ALU_ORR = 3'd3;
	localparam aluOpT ALU_XOR = 3'd4;
	localparam aluOpT ALU_ADDI = 3'd5;

	// Register write sources
	localparam resSelT RES_ALU = 2'd0;
	localparam resSelT RES_SHIFT = 2'd1;
	localparam resSelT RES_IMM = 2'd2;
	localparam resSelT RES_MEM = 2'd3;

	// APB byte addresses, word index is paddr[9:2]
	localparam int APB_ADDR_W = 12;
	localparam logic [APB_ADDR_W-1:0] APB_CTRL = 12'h000;
	localparam logic [APB_ADDR_W-1:0] APB_REG_BASE = 12'h040;
	localparam logic [APB_ADDR_W-1:0] APB_IMEM_BASE = 12'h400;
	localparam logic [APB_ADDR_W-1:0] APB_DMEM_BASE = 12'h800;

endpackage

`default_nettype wire

/* cpuTb.sv */
`timescale 1ns/1ps
`default_nettype none

module cpuTb import cpuPkg::*; ();

	localparam int CYCLE_LIMIT = 5000;
	// Longest run is the write-while-running loop at about 750 cycles or 250 polls
	localparam int POLL_LIMIT = 500;
	localparam int LONG_COUNT = 150;

	logic clk;
	logic reset;
	logic psel;
	logic penable;
	logic pwrite;
	logic [APB_ADDR_W-1:0] paddr;
	dataT pwdata;
	dataT prdata;
	logic pready;
	logic pslverr;

	// Program image loaded from word 0
	instrT prog[$];
	logic [15:0] lfsrState = 16'd21;
	int cycles = 0;

	cpuTop i_cpuTop (
		.clk, .reset, .psel, .penable, .pwrite, .paddr, .pwdata,
		.prdata, .pready, .pslverr
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// Run guard
	initial begin
		while (cycles < CYCLE_LIMIT) begin
			@(posedge clk);
			cycles++;
		end
		$display("Timeout after %0d cycles without finishing the tests", cycles);
		$display("TESTS FAILED");
		$fatal(1);
	end

	task automatic failRun(input string msg);
		$display("%s", msg);
		$display("TESTS FAILED");
		$fatal(1);
	endtask

	task automatic checkEq(input string name, input logic [15:0] got, input logic [15:0] exp);
		if (got !== exp) begin
			failRun($sformatf("Mismatch at %0t ns: %s got 0x%04h expected 0x%04h",
				$time, name, got, exp));
		end
	endtask

	// Galois LFSR stepped once per bit
	function automatic logic [15:0] randBits(input int n);
		logic [15:0] value;
		logic bitOut;
		value = '0;
		for (int i = 0; i < n; i++) begin
			bitOut = lfsrState[0];
			lfsrState = (lfsrState >> 1) ^ (bitOut ? 16'hB400 : 16'h0000);
			value = {value[14:0], bitOut};
		end
		return value;
	endfunction

	// Instruction encoders
	function automatic instrT encR(input logic [3:0] op, input int rd, input int rn, input int rm);
		return {op, 3'(rd), 3'(rn), 3'(rm), 3'b0};
	endfunction

	function automatic instrT encI(input logic [3:0] op, input int rd, input logic [7:0] imm);
		return {op, 3'(rd), 1'b0, imm};
	endfunction

	function automatic instrT encSh(input logic [3:0] op, input int rd, input int rn,
		input logic [3:0] sh);
		return {op, 3'(rd), 3'(rn), 2'b0, sh};
	endfunction

	function automatic instrT encMem(input logic [3:0] op, input int rd, input int rn,
		input logic [5:0] off);
		return {op, 3'(rd), 3'(rn), off};
	endfunction

	function automatic instrT encBc(input logic [3:0] cond, input logic [7:0] off);
		return {OP_BCOND, cond, off};
	endfunction

	function automatic instrT encB(input logic [11:0] off);
		return {OP_B, off};
	endfunction

	// Full 16-bit constant in three instructions
	task automatic pushLoad16(input int rd, input logic [15:0] value);
		prog.push_back(encI(OP_MOVI, rd, value[15:8]));
		prog.push_back(encSh(OP_LSL, rd, rd, 4'd8));
		prog.push_back(encI(OP_ADDI, rd, value[7:0]));
	endtask

	// Condition rule on NZCV
	function automatic logic condHolds(input int cond, input logic n, input logic z,
		input logic c, input logic v);
		case (cond)
			0: return z;
			1: return !z;
			2: return c;
			3: return !c;
			4: return n;
			5: return !n;
			6: return v;
			7: return !v;
			8: return n == v;
			9: return n != v;
			default: return 1'b1;
		endcase
	endfunction

	task automatic apbTransfer(input logic wr, input logic [APB_ADDR_W-1:0] addr,
		input dataT wdata, output dataT rdata, output logic err);
		@(posedge clk);
		#1;
		psel = 1'b1;
		penable = 1'b0;
		pwrite = wr;
		paddr = addr;
		pwdata = wdata;
		@(posedge clk);
		#1;
		penable = 1'b1;
		// Registered response stays stable through the access phase
		checkEq("pready", pready, 1'b1);
		rdata = prdata;
		err = pslverr;
		@(posedge clk);
		#1;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
	endtask

	task automatic apbWrite(input logic [APB_ADDR_W-1:0] addr, input dataT data);
		dataT unused;
		logic err;
		apbTransfer(1'b1, addr, data, unused, err);
		checkEq("pslverr", err, 1'b0);
	endtask

	task automatic apbRead(input logic [APB_ADDR_W-1:0] addr, output dataT data);
		logic err;
		apbTransfer(1'b0, addr, '0, data, err);
		checkEq("pslverr", err, 1'b0);
	endtask

	task automatic checkReg(input int idx, input dataT exp);
		dataT value;
		apbRead(APB_REG_BASE + 12'(idx * 4), value);
		checkEq($sformatf("r%0d", idx), value, exp);
	endtask

	task automatic loadProgram();
		for (int i = 0; i < prog.size(); i++) begin
			apbWrite(APB_IMEM_BASE + 12'(i * 4), prog[i]);
		end
	endtask

	task automatic waitHalted();
		dataT ctrl;
		int polls;
		ctrl = '0;
		polls = 0;
		while (!ctrl[1] && polls < POLL_LIMIT) begin
			apbRead(APB_CTRL, ctrl);
			polls++;
		end
		if (!ctrl[1]) begin
			failRun("Core never reported halted after start");
		end
		checkEq("CTRL", ctrl, 16'h0002);
	endtask

	task automatic runProgram();
		loadProgram();
		apbWrite(APB_CTRL, 16'h0001);
		waitHalted();
	endtask

	task automatic testReset();
		dataT value;
		logic err;
		apbRead(APB_CTRL, value);
		checkEq("CTRL", value, 16'h0000);
		for (int i = 0; i < NUM_REGS; i++) begin
			checkReg(i, 16'h0000);
		end
		// Unmapped address and a write to the read-only register window
		apbTransfer(1'b0, 12'h100, '0, value, err);
		checkEq("pslverr unmapped", err, 1'b1);
		apbTransfer(1'b1, APB_REG_BASE, 16'h1234, value, err);
		checkEq("pslverr reg write", err, 1'b1);
	endtask

	task automatic testAlu();
		dataT m [NUM_REGS];
		logic [7:0] a, b, c;
		logic [3:0] s1, s2;
		a = 8'(randBits(8));
		b = 8'(randBits(8));
		c = 8'(randBits(8));
		s1 = 4'(randBits(4));
		s2 = 4'(randBits(4));
		prog.delete();
		prog.push_back(encI(OP_MOVI, 1, a));
		prog.push_back(encI(OP_MOVI, 2, b));
		prog.push_back(encR(OP_ADD, 3, 1, 2));
		prog.push_back(encR(OP_SUB, 4, 3, 1));
		prog.push_back(encR(OP_AND, 5, 4, 3));
		prog.push_back(encR(OP_ORR, 6, 5, 2));
		prog.push_back(encR(OP_XOR, 7, 6, 3));
		prog.push_back(encI(OP_ADDI, 7, c));
		prog.push_back(encSh(OP_LSL, 1, 7, s1));
		prog.push_back(encSh(OP_LSR, 2, 1, s2));
		prog.push_back({OP_HALT, 12'h000});
		runProgram();
		// Expected values from the instruction rules
		m[0] = 16'h0000;
		m[1] = {8'h00, a};
		m[2] = {8'h00, b};
		m[3] = m[1] + m[2];
		m[4] = m[3] - m[1];
		m[5] = m[4] & m[3];
		m[6] = m[5] | m[2];
		m[7] = (m[6] ^ m[3]) + {8'h00, c};
		m[1] = m[7] << s1;
		m[2] = m[1] >> s2;
		for (int i = 0; i < NUM_REGS; i++) begin
			checkReg(i, m[i]);
		end
	endtask

	task automatic testBranches();
		dataT a, b, diff;
		int sd;
		logic n, z, c, v, taken;
		for (int cond = 0; cond < 10; cond++) begin
			for (int k = 0; k < 3; k++) begin
				a = randBits(16);
				b = randBits(16);
				if (k == 1) begin
					// Equal operands
					b = a;
				end else if (k == 2) begin
					// Signed overflow case
					a = 16'h8000;
					b = 16'h0001;
				end
				prog.delete();
				pushLoad16(1, a);
				pushLoad16(2, b);
				prog.push_back(encI(OP_MOVI, 3, 8'h00));
				prog.push_back(encI(OP_MOVI, 5, 8'h00));
				prog.push_back(encR(OP_SUB, 4, 1, 2));
				// Skips both markers when taken
				prog.push_back(encBc(4'(cond), 8'd2));
				prog.push_back(encI(OP_MOVI, 3, 8'h01));
				prog.push_back(encI(OP_MOVI, 5, 8'h01));
				prog.push_back({OP_HALT, 12'h000});
				runProgram();
				diff = a - b;
				n = diff[15];
				z = (diff == 16'h0000);
				// Carry means no borrow
				c = (a >= b);
				sd = int'($signed(a)) - int'($signed(b));
				v = (sd > 32767) || (sd < -32768);
				taken = condHolds(cond, n, z, c, v);
				checkReg(4, diff);
				checkReg(3, taken ? 16'h0000 : 16'h0001);
				checkReg(5, taken ? 16'h0000 : 16'h0001);
			end
		end
	endtask

	task automatic testMemory();
		logic [7:0] base;
		logic [5:0] off3;
		dataT v1, v2, v3, value;
		base = 8'(randBits(5));
		off3 = 6'(randBits(5)) + 6'd2;
		v1 = randBits(16);
		v2 = randBits(16);
		v3 = randBits(16);
		prog.delete();
		prog.push_back(encI(OP_MOVI, 1, base));
		pushLoad16(2, v1);
		pushLoad16(3, v2);
		pushLoad16(4, v3);
		prog.push_back(encMem(OP_STR, 2, 1, 6'd0));
		prog.push_back(encMem(OP_STR, 3, 1, 6'd1));
		prog.push_back(encMem(OP_STR, 4, 1, off3));
		prog.push_back(encMem(OP_LDR, 5, 1, 6'd0));
		prog.push_back(encMem(OP_LDR, 6, 1, 6'd1));
		prog.push_back(encMem(OP_LDR, 7, 1, off3));
		prog.push_back({OP_HALT, 12'h000});
		runProgram();
		apbRead(APB_DMEM_BASE + 12'(base * 4), value);
		checkEq("dmem[base]", value, v1);
		apbRead(APB_DMEM_BASE + 12'((base + 1) * 4), value);
		checkEq("dmem[base+1]", value, v2);
		apbRead(APB_DMEM_BASE + 12'((base + off3) * 4), value);
		checkEq("dmem[base+off]", value, v3);
		checkReg(5, v1);
		checkReg(6, v2);
		checkReg(7, v3);
	endtask

	task automatic testLoop();
		logic [7:0] count;
		count = 8'(randBits(3)) + 8'd5;
		prog.delete();
		prog.push_back(encI(OP_MOVI, 1, count));
		prog.push_back(encI(OP_MOVI, 2, 8'h00));
		prog.push_back(encI(OP_MOVI, 3, 8'h00));
		prog.push_back(encI(OP_MOVI, 4, 8'h01));
		prog.push_back(encI(OP_MOVI, 5, 8'h00));
		prog.push_back(encI(OP_MOVI, 6, 8'h00));
		// Loop body at word 6
		prog.push_back(encR(OP_ADD, 2, 2, 1));
		prog.push_back(encI(OP_ADDI, 3, 8'h01));
		prog.push_back(encR(OP_SUB, 1, 1, 4));
		prog.push_back(encBc(COND_EQ, 8'd1));
		prog.push_back(encB(12'hFFB));
		prog.push_back({OP_HALT, 12'h000});
		// Never reached
		prog.push_back(encI(OP_MOVI, 5, 8'hAA));
		prog.push_back(encI(OP_MOVI, 6, 8'h55));
		runProgram();
		checkReg(1, 16'h0000);
		checkReg(2, 16'(count * (count + 1) / 2));
		checkReg(3, {8'h00, count});
		checkReg(5, 16'h0000);
		checkReg(6, 16'h0000);
	endtask

	task automatic testWriteWhileRunning();
		dataT value;
		logic err;
		prog.delete();
		prog.push_back(encI(OP_MOVI, 1, 8'(LONG_COUNT)));
		prog.push_back(encI(OP_MOVI, 2, 8'h00));
		prog.push_back(encI(OP_MOVI, 4, 8'h01));
		prog.push_back(encI(OP_ADDI, 2, 8'h03));
		prog.push_back(encR(OP_SUB, 1, 1, 4));
		prog.push_back(encBc(COND_NE, 8'hFD));
		prog.push_back({OP_HALT, 12'h000});
		loadProgram();
		apbWrite(APB_CTRL, 16'h0001);
		apbRead(APB_CTRL, value);
		checkEq("CTRL running", value, 16'h0001);
		// Try to overwrite the loop body with a NOP
		apbTransfer(1'b1, APB_IMEM_BASE + 12'(3 * 4), {OP_NOP, 12'h000}, value, err);
		checkEq("pslverr imem while running", err, 1'b1);
		waitHalted();
		checkReg(1, 16'h0000);
		checkReg(2, 16'(3 * LONG_COUNT));
	endtask

	initial begin
		reset = 1'b1;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		repeat (4) @(posedge clk);
		#1;
		reset = 1'b0;
		testReset();
		testAlu();
		testBranches();
		testMemory();
		testLoop();
		testWriteWhileRunning();
		$display("TESTS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

/* cpuTop.sv */
`timescale 1ns/1ps
`default_nettype none

module cpuTop import cpuPkg::*; (
	input wire clk,
	input wire reset,
	input wire psel,
	input wire penable,
	input wire pwrite,
	input wire logic [APB_ADDR_W-1:0] paddr,
	input wire dataT pwdata,
	output dataT prdata,
	output logic pready,
	output logic pslverr
);

	// Debug port to core
	logic run, start, imemWe, haltSeen;
	memAddrT imemAddr, dbgMemAddr;
	instrT imemData;
	regAddrT dbgRegAddr;
	dataT dbgRegData, dbgMemData;

	// Fetch to decode
	instrT fetchInstr;
	memAddrT fetchPc;
	logic fetchValid;

	// Register file ports
	regAddrT rdAddrA, rdAddrB, regWaddr;
	dataT rdDataA, rdDataB, regWdata;
	logic regWe;

	// Execute stage controls
	logic exValid, exSetFlags, exShiftLeft, exBranch, exCondBranch;
	logic exMemWrite, exRegWrite, exHalt;
	dataT exOpA, exOpB, exImm, exOffset, exStoreData;
	aluOpT exAluOp;
	logic [3:0] exShamt, exCond;
	memAddrT exPc;
	resSelT exResSel;
	regAddrT exWaddr;

	// Execute results
	dataT aluResult, shiftResult;
	logic branchTaken;
	memAddrT branchTarget;

	regFile i_regFile (
		.clk, .reset,
		.rdAddrA, .rdAddrB, .dbgAddr(dbgRegAddr),
		.rdDataA, .rdDataB, .dbgData(dbgRegData),
		.we(regWe), .wAddr(regWaddr), .wData(regWdata)
	);

	fetchUnit i_fetchUnit (
		.clk, .reset, .run, .start, .branchTaken, .branchTarget,
		.imemWe, .imemAddr, .imemData,
		.fetchInstr, .fetchPc, .fetchValid
	);

	instrDecode i_instrDecode (
		.clk, .reset, .fetchInstr, .fetchPc, .fetchValid, .branchTaken, .haltSeen,
		.rdAddrA, .rdAddrB, .rdDataA, .rdDataB,
		.exValid, .exOpA, .exOpB, .exImm, .exAluOp, .exSetFlags, .exShiftLeft,
		.exShamt, .exCond, .exBranch, .exCondBranch, .exOffset, .exPc,
		.exMemWrite, .exStoreData, .exResSel, .exRegWrite, .exWaddr, .exHalt
	);

	execUnit i_execUnit (
		.clk, .reset, .exValid, .exOpA, .exOpB, .exImm, .exAluOp, .exSetFlags,
		.exShiftLeft, .exShamt, .exCond, .exBranch, .exCondBranch, .exOffset,
		.exPc, .exHalt,
		.aluResult, .shiftResult, .branchTaken, .branchTarget, .haltSeen
	);

	writeBack i_writeBack (
		.clk, .exValid, .exMemWrite, .exRegWrite, .exResSel, .exWaddr, .exImm,
		.exStoreData, .aluResult, .shiftResult, .dbgMemAddr, .dbgMemData,
		.regWe, .regWaddr, .regWdata
	);

	apbDebug i_apbDebug (
		.clk, .reset, .psel, .penable, .pwrite, .paddr, .pwdata,
		.prdata, .pready, .pslverr, .haltSeen,
		.run, .start, .imemWe, .imemAddr, .imemData,
		.dbgRegAddr, .dbgMemAddr, .dbgRegData, .dbgMemData
	);

endmodule

`default_nettype wire

/* execUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module execUnit import cpuPkg::*; (
	input wire clk,
	input wire reset,
	input wire exValid,
	input wire dataT exOpA,
	input wire dataT exOpB,
	input wire dataT exImm,
	input wire aluOpT exAluOp,
	input wire exSetFlags,
	input wire exShiftLeft,
	input wire logic [3:0] exShamt,
	input wire logic [3:0] exCond,
	input wire exBranch,
	input wire exCondBranch,
	input wire dataT exOffset,
	input wire memAddrT exPc,
	input wire exHalt,
	output dataT aluResult,
	output dataT shiftResult,
	output logic branchTaken,
	output memAddrT branchTarget,
	output logic haltSeen
);

	dataT aluB;
	logic [16:0] sum;
	logic carry, overflow;
	flagsT flags;
	logic condTrue;

	// ADDI, LDR and STR take the immediate as operand B
	assign aluB = (exAluOp == ALU_ADDI) ? exImm : exOpB;

	// ALU with carry and signed overflow
	always_comb begin
		sum = '0;
		carry = flags[FLAG_C];
		overflow = flags[FLAG_V];
		case (exAluOp)
			ALU_ADD, ALU_ADDI: begin
				sum = {1'b0, exOpA} + {1'b0, aluB};
				aluResult = sum[15:0];
				carry = sum[16];
				overflow = (exOpA[15] == aluB[15]) && (aluResult[15] != exOpA[15]);
			end
			ALU_SUB: begin
				// A plus not B plus one, carry set means no borrow
				sum = {1'b0, exOpA} + {1'b0, ~aluB} + 17'd1;
				aluResult = sum[15:0];
				carry = sum[16];
				overflow = (exOpA[15] != aluB[15]) && (aluResult[15] != exOpA[15]);
			end
			// Logic ops keep C and V
			ALU_AND: aluResult = exOpA & aluB;
			ALU_ORR: aluResult = exOpA | aluB;
			ALU_XOR: aluResult = exOpA ^ aluB;
			default: aluResult = exOpA;
		endcase
	end

	// Shifter, zero fill both ways
	assign shiftResult = exShiftLeft ? (exOpA << exShamt) : (exOpA >> exShamt);

	// NZCV register
	always_ff @(posedge clk) begin
		if (reset) begin
			flags <= '0;
		end else if (exValid && exSetFlags) begin
			flags <= {aluResult[15], (aluResult == '0), carry, overflow};
		end
	end

	// Condition test on the stored flags
	always_comb begin
		case (exCond)
			COND_EQ: condTrue = flags[FLAG_Z];
			COND_NE: condTrue = !flags[FLAG_Z];
			COND_CS: condTrue = flags[FLAG_C];
			COND_CC: condTrue = !flags[FLAG_C];
			COND_MI: condTrue = flags[FLAG_N];
			COND_PL: condTrue = !flags[FLAG_N];
			COND_VS: condTrue = flags[FLAG_V];
			COND_VC: condTrue = !flags[FLAG_V];
			COND_GE: condTrue = (flags[FLAG_N] == flags[FLAG_V]);
			COND_LT: condTrue = (flags[FLAG_N] != flags[FLAG_V]);
			default: condTrue = 1'b1;
		endcase
	end

	// Branch resolves here, target relative to the next word
	assign branchTaken = exValid && exBranch && (!exCondBranch || condTrue);
	assign branchTarget = exPc + 8'd1 + exOffset[7:0];

	assign haltSeen = exValid && exHalt;

	// A taken branch leaves a bubble behind it in execute
	branchFlush: assert property (@(posedge clk) disable iff (reset)
		branchTaken |-> exValid ##1 !exValid);

endmodule

`default_nettype wire

/* fetchUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module fetchUnit import cpuPkg::*; (
	input wire clk,
	input wire reset,
	input wire run,
	input wire start,
	input wire branchTaken,
	input wire memAddrT branchTarget,
	input wire imemWe,
	input wire memAddrT imemAddr,
	input wire instrT imemData,
	output instrT fetchInstr,
	output memAddrT fetchPc,
	output logic fetchValid
);

	instrT imem [IMEM_DEPTH];
	memAddrT pc;

	// Program load from the debug port
	always_ff @(posedge clk) begin
		if (imemWe) begin
			imem[imemAddr] <= imemData;
		end
	end

	// Start restarts at word 0
	// a taken branch redirects, otherwise step while running
	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= '0;
		end else if (start) begin
			pc <= '0;
		end else if (branchTaken) begin
			pc <= branchTarget;
		end else if (run) begin
			pc <= pc + 8'd1;
		end
	end

	// Wrong-path fetch after a branch is dropped
	// Nothing valid leaves fetch while stopped or halting
	always_ff @(posedge clk) begin
		if (reset) begin
			fetchValid <= 1'b0;
		end else begin
			fetchValid <= run && !branchTaken && !start;
		end
	end

	// Fetch register
	always_ff @(posedge clk) begin
		fetchInstr <= imem[pc];
		fetchPc <= pc;
	end

	// Program memory only changes while the core is stopped
	imemWriteStopped: assert property (@(posedge clk) disable iff (reset)
		imemWe |-> !run);

endmodule

`default_nettype wire

/* filelist.f */
cpuPkg.sv
regFile.sv
fetchUnit.sv
instrDecode.sv
execUnit.sv
writeBack.sv
apbDebug.sv
cpuTop.sv
cpuTb.sv

/* instrDecode.sv */
`timescale 1ns/1ps
`default_nettype none

module instrDecode import cpuPkg::*; (
	input wire clk,
	input wire reset,
	input wire instrT fetchInstr,
	input wire memAddrT fetchPc,
	input wire fetchValid,
	input wire branchTaken,
	input wire haltSeen,
	output regAddrT rdAddrA,
	output regAddrT rdAddrB,
	input wire dataT rdDataA,
	input wire dataT rdDataB,
	output logic exValid,
	output dataT exOpA,
	output dataT exOpB,
	output dataT exImm,
	output aluOpT exAluOp,
	output logic exSetFlags,
	output logic exShiftLeft,
	output logic [3:0] exShamt,
	output logic [3:0] exCond,
	output logic exBranch,
	output logic exCondBranch,
	output dataT exOffset,
	output memAddrT exPc,
	output logic exMemWrite,
	output dataT exStoreData,
	output resSelT exResSel,
	output logic exRegWrite,
	output regAddrT exWaddr,
	output logic exHalt
);

	logic [3:0] opcode;
	aluOpT aluOp;
	resSelT resSel;
	logic setFlags, regWrite, memWrite;
	logic isBranch, isCondBranch, isHalt;
	dataT imm;
	dataT offset;

	assign opcode = fetchInstr[15:12];

	// ADDI reads its own destination, STR reads the store data on port B
	assign rdAddrA = (opcode == OP_ADDI) ? fetchInstr[11:9] : fetchInstr[8:6];
	assign rdAddrB = (opcode == OP_STR) ? fetchInstr[11:9] : fetchInstr[5:3];

	// Control unit
	always_comb begin
		aluOp = ALU_ADD;
		resSel = RES_ALU;
		setFlags = 1'b0;
		regWrite = 1'b0;
		memWrite = 1'b0;
		isBranch = 1'b0;
		isCondBranch = 1'b0;
		isHalt = 1'b0;
		// 8-bit immediate, zero extended
		imm = {8'b0, fetchInstr[7:0]};
		// Signed 8-bit condition branch offset
		offset = {{8{fetchInstr[7]}}, fetchInstr[7:0]};
		case (opcode)
			OP_ADD, OP_SUB, OP_AND, OP_ORR, OP_XOR: begin
				aluOp = aluOpT'(opcode[2:0]);
				setFlags = 1'b1;
				regWrite = 1'b1;
			end
			OP_ADDI: begin
				aluOp = ALU_ADDI;
				setFlags = 1'b1;
				regWrite = 1'b1;
			end
			OP_MOVI: begin
				resSel = RES_IMM;
				regWrite = 1'b1;
			end
			OP_LSL, OP_LSR: begin
				resSel = RES_SHIFT;
				regWrite = 1'b1;
			end
			OP_LDR, OP_STR: begin
				// Base plus 6-bit offset
				aluOp = ALU_ADDI;
				imm = {10'b0, fetchInstr[5:0]};
				resSel = RES_MEM;
				regWrite = (opcode == OP_LDR);
				memWrite = (opcode == OP_STR);
			end
			OP_BCOND: begin
				isBranch = 1'b1;
				isCondBranch = 1'b1;
			end
			OP_B: begin
				isBranch = 1'b1;
				offset = {{4{fetchInstr[11]}}, fetchInstr[11:0]};
			end
			OP_HALT: isHalt = 1'b1;
			// NOP and reserved opcode keep the defaults
			default: isHalt = 1'b0;
		endcase
	end

	// Control half of the decode-to-execute register
	always_ff @(posedge clk) begin
		if (reset) begin
			exValid <= 1'b0;
			exSetFlags <= 1'b0;
			exBranch <= 1'b0;
			exCondBranch <= 1'b0;
			exMemWrite <= 1'b0;
			exRegWrite <= 1'b0;
			exHalt <= 1'b0;
		end else begin
			// Flush on a taken branch or a halt in execute
			exValid <= fetchValid && !branchTaken && !haltSeen;
			exSetFlags <= setFlags;
			exBranch <= isBranch;
			exCondBranch <= isCondBranch;
			exMemWrite <= memWrite;
			exRegWrite <= regWrite;
			exHalt <= isHalt;
		end
	end

	// Payload half
	always_ff @(posedge clk) begin
		exOpA <= rdDataA;
		exOpB <= rdDataB;
		exStoreData <= rdDataB;
		exImm <= imm;
		exAluOp <= aluOp;
		exShiftLeft <= (opcode == OP_LSL);
		exShamt <= fetchInstr[3:0];
		exCond <= fetchInstr[11:8];
		exOffset <= offset;
		exPc <= fetchPc;
		exResSel <= resSel;
		exWaddr <= fetchInstr[11:9];
	end

	// Reserved opcode reaches execute with no side effects
	rsvdIsNop: assert property (@(posedge clk) disable iff (reset)
		(fetchValid && opcode == OP_RSVD) |=>
		!(exRegWrite || exMemWrite || exBranch || exHalt || exSetFlags));

endmodule

`default_nettype wire

/* regFile.sv */
`timescale 1ns/1ps
`default_nettype none

module regFile import cpuPkg::*; (
	input wire clk,
	input wire reset,
	input wire regAddrT rdAddrA,
	input wire regAddrT rdAddrB,
	input wire regAddrT dbgAddr,
	output dataT rdDataA,
	output dataT rdDataB,
	output dataT dbgData,
	input wire we,
	input wire regAddrT wAddr,
	input wire dataT wData
);

	dataT regs [NUM_REGS];

	// Write on the rising edge, all registers clear on reset
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (we) begin
			regs[wAddr] <= wData;
		end
	end

	// Write-through so decode sees the result leaving execute this cycle
	assign rdDataA = (we && (wAddr == rdAddrA)) ? wData : regs[rdAddrA];
	assign rdDataB = (we && (wAddr == rdAddrB)) ? wData : regs[rdAddrB];

	// Debug port sees stored state only
	assign dbgData = regs[dbgAddr];

endmodule

`default_nettype wire

/* writeBack.sv */
`timescale 1ns/1ps
`default_nettype none

module writeBack import cpuPkg::*; (
	input wire clk,
	input wire exValid,
	input wire exMemWrite,
	input wire exRegWrite,
	input wire resSelT exResSel,
	input wire regAddrT exWaddr,
	input wire dataT exImm,
	input wire dataT exStoreData,
	input wire dataT aluResult,
	input wire dataT shiftResult,
	input wire memAddrT dbgMemAddr,
	output dataT dbgMemData,
	output logic regWe,
	output regAddrT regWaddr,
	output dataT regWdata
);

	dataT dmem [DMEM_DEPTH];
	memAddrT memAddr;
	logic memWe;
	dataT memData;

	// Word address from the ALU sum
	assign memAddr = aluResult[7:0];
	assign memWe = exValid && exMemWrite;

	always_ff @(posedge clk) begin
		if (memWe) begin
			dmem[memAddr] <= exStoreData;
		end
	end

	// Combinational reads for LDR and the debug window
	assign memData = dmem[memAddr];
	assign dbgMemData = dmem[dbgMemAddr];

	// Result select
	always_comb begin
		case (exResSel)
			RES_SHIFT: regWdata = shiftResult;
			RES_IMM: regWdata = exImm;
			RES_MEM: regWdata = memData;
			default: regWdata = aluResult;
		endcase
	end

	assign regWe = exValid && exRegWrite;
	assign regWaddr = exWaddr;

endmodule

`default_nettype wire
